//--- rtl/tpu_uart_pkg.sv
package tpu_uart_pkg;

    // Serial line timing
    localparam int clock_freq   = 10_000_000;
    localparam int baud_rate    = 625_000;
    localparam int clks_per_bit = clock_freq / baud_rate;

    // Counter wide enough for one bit period
    typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;

    // Last cycle of a bit, and the cycle at its centre
    localparam baud_cnt_t bit_last = baud_cnt_t'(clks_per_bit - 1);
    localparam baud_cnt_t bit_half = baud_cnt_t'(clks_per_bit / 2 - 1);

    // Payload widths
    typedef logic [7:0]         byte_t;
    typedef logic [15:0]        act_row_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [3:0]         mlp_state_t;
    typedef logic [4:0]         cycle_cnt_t;

    // Host command codes
    typedef enum logic [7:0] {
        cmd_write_weight = 8'h01,
        cmd_write_act    = 8'h02,
        cmd_execute      = 8'h03,
        cmd_read_result  = 8'h04,
        cmd_status       = 8'h05
    } cmd_t;

    // Data bytes after a write command
    localparam int load_bytes = 4;

    // Bytes in a read result response
    localparam int result_bytes = 4;

endpackage

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import tpu_uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rx,
    output byte_t rx_data,
    output logic  rx_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t state;
    logic      rx_meta;
    logic      rx_sync;
    baud_cnt_t clk_cnt;
    logic [2:0] bit_idx;
    byte_t     shift_reg;

    // Two-flop synchroniser, idles high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            clk_cnt   <= '0;
            bit_idx   <= 3'd0;
            shift_reg <= '0;
            rx_data   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // Recheck at mid start bit so a glitch is not taken as a frame
                    if (clk_cnt == bit_half) begin
                        clk_cnt <= '0;
                        bit_idx <= 3'd0;
                        state   <= rx_sync ? st_idle : st_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt   <= '0;
                        // LSB arrives first
                        shift_reg <= {rx_sync, shift_reg[7:1]};
                        bit_idx   <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        state   <= st_idle;
                        // Framing error drops the byte
                        if (rx_sync) begin
                            rx_data  <= shift_reg;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_rx_valid_single: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import tpu_uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_data,
    input  logic  tx_valid,
    output logic  tx_ready,
    output logic  tx
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_t;

    tx_state_t  state;
    baud_cnt_t  clk_cnt;
    logic [2:0] bit_idx;
    byte_t      shift_reg;

    assign tx_ready = (state == st_idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            clk_cnt   <= '0;
            bit_idx   <= 3'd0;
            shift_reg <= '0;
            tx        <= 1'b1;
        end else begin
            if (state != st_idle) begin
                clk_cnt <= (clk_cnt == bit_last) ? '0 : clk_cnt + 1'b1;
            end
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (tx_valid) begin
                        shift_reg <= tx_data;
                        tx        <= 1'b0;
                        state     <= st_start;
                    end
                end
                st_start: begin
                    if (clk_cnt == bit_last) begin
                        tx      <= shift_reg[0];
                        bit_idx <= 3'd0;
                        state   <= st_data;
                    end
                end
                st_data: begin
                    if (clk_cnt == bit_last) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= st_stop;
                        end else begin
                            tx        <= shift_reg[1];
                            shift_reg <= shift_reg >> 1;
                            bit_idx   <= bit_idx + 3'd1;
                        end
                    end
                end
                st_stop: begin
                    // Line already high, just hold for one bit
                    if (clk_cnt == bit_last) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
        tx_ready |-> tx);

endmodule

//--- rtl/cmd_ctrl.sv
`timescale 1ns/1ps

module cmd_ctrl
    import tpu_uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t rx_data,
    input  logic  rx_valid,
    input  logic  load_done,
    input  logic  resp_done,
    output logic  load_en,
    output logic  load_weight,
    output logic  start_mlp,
    output logic  capture_result,
    output logic  capture_status
);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_respond
    } ctrl_state_t;

    ctrl_state_t state;

    // Loader takes data bytes only while this is high
    assign load_en = (state == st_load);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= st_idle;
            load_weight    <= 1'b0;
            start_mlp      <= 1'b0;
            capture_result <= 1'b0;
            capture_status <= 1'b0;
        end else begin
            start_mlp      <= 1'b0;
            capture_result <= 1'b0;
            capture_status <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_valid) begin
                        case (rx_data)
                            cmd_write_weight: begin
                                load_weight <= 1'b1;
                                state       <= st_load;
                            end
                            cmd_write_act: begin
                                load_weight <= 1'b0;
                                state       <= st_load;
                            end
                            cmd_execute: begin
                                start_mlp <= 1'b1;
                            end
                            cmd_read_result: begin
                                capture_result <= 1'b1;
                                state          <= st_respond;
                            end
                            cmd_status: begin
                                capture_status <= 1'b1;
                                state          <= st_respond;
                            end
                            // Unknown codes are ignored
                            default: state <= st_idle;
                        endcase
                    end
                end
                st_load: begin
                    if (load_done) begin
                        state <= st_idle;
                    end
                end
                st_respond: begin
                    // Incoming bytes are dropped until the reply is out
                    if (resp_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Serializer only finishes a reply that a capture requested
    a_reply_requested: assert property (@(posedge clk) disable iff (rst)
        resp_done |-> (state == st_respond));

endmodule

//--- rtl/mlp_loader.sv
`timescale 1ns/1ps

module mlp_loader
    import tpu_uart_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  byte_t    rx_data,
    input  logic     rx_valid,
    input  logic     load_en,
    input  logic     load_weight,
    output logic     wf_push_col0,
    output logic     wf_push_col1,
    output byte_t    wf_data_in,
    output logic     init_act_valid,
    output act_row_t init_act_data,
    output logic     weights_ready,
    output logic     load_done
);

    byte_t      buffer [load_bytes];
    logic [1:0] byte_cnt;
    logic [1:0] seq_idx;
    logic       replay;
    logic       take_byte;
    logic       last_out;

    assign take_byte = rx_valid && load_en && !replay;

    // Four pushes for weights, two rows for activations
    assign last_out = load_weight ? (seq_idx == 2'(load_bytes - 1))
                                  : (seq_idx == 2'(load_bytes / 2 - 1));
    assign load_done = replay && last_out;

    // Weights alternate col0, col1
    assign wf_push_col0 = replay && load_weight && !seq_idx[0];
    assign wf_push_col1 = replay && load_weight && seq_idx[0];
    assign wf_data_in   = buffer[seq_idx];

    // Row n is {d(2n+1), d(2n)}
    assign init_act_valid = replay && !load_weight;
    assign init_act_data  = {buffer[{seq_idx[0], 1'b1}], buffer[{seq_idx[0], 1'b0}]};

    always_ff @(posedge clk) begin
        if (take_byte) begin
            buffer[byte_cnt] <= rx_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_cnt      <= 2'd0;
            seq_idx       <= 2'd0;
            replay        <= 1'b0;
            weights_ready <= 1'b0;
        end else begin
            if (take_byte) begin
                if (byte_cnt == 2'(load_bytes - 1)) begin
                    byte_cnt <= 2'd0;
                    seq_idx  <= 2'd0;
                    replay   <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
            if (replay) begin
                seq_idx <= seq_idx + 2'd1;
                if (last_out) begin
                    replay <= 1'b0;
                end
                // Raised so it is seen together with the fourth push
                if (load_weight && seq_idx == 2'(load_bytes - 2)) begin
                    weights_ready <= 1'b1;
                end
            end
        end
    end

    // Ready flag comes up on the last col1 push
    a_ready_with_push: assert property (@(posedge clk) disable iff (rst)
        $rose(weights_ready) |-> wf_push_col1);

endmodule

//--- rtl/resp_serializer.sv
`timescale 1ns/1ps

module resp_serializer
    import tpu_uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       capture_result,
    input  logic       capture_status,
    input  mlp_state_t mlp_state,
    input  cycle_cnt_t mlp_cycle_cnt,
    input  acc_t       mlp_acc0,
    input  logic       tx_ready,
    output byte_t      tx_data,
    output logic       tx_valid,
    output logic       resp_done
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_send,
        ph_drain
    } phase_t;

    phase_t     phase;
    byte_t      buffer [result_bytes];
    logic [2:0] byte_cnt;
    logic [1:0] byte_idx;
    logic       last_byte;

    assign tx_valid  = (phase == ph_send);
    assign tx_data   = buffer[byte_idx];
    assign last_byte = ({1'b0, byte_idx} == byte_cnt - 3'd1);

    // Transmitter back to idle after the final stop bit
    assign resp_done = (phase == ph_drain) && tx_ready;

    always_ff @(posedge clk) begin
        if (capture_result) begin
            // Accumulator goes out LSB first
            for (int i = 0; i < result_bytes; i++) begin
                buffer[i] <= mlp_acc0[8*i +: 8];
            end
        end else if (capture_status) begin
            buffer[0] <= {mlp_state[2:0], mlp_cycle_cnt};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= ph_idle;
            byte_cnt <= 3'd0;
            byte_idx <= 2'd0;
        end else begin
            case (phase)
                ph_idle: begin
                    byte_idx <= 2'd0;
                    if (capture_result) begin
                        byte_cnt <= 3'(result_bytes);
                        phase    <= ph_send;
                    end else if (capture_status) begin
                        byte_cnt <= 3'd1;
                        phase    <= ph_send;
                    end
                end
                ph_send: begin
                    if (tx_ready) begin
                        if (last_byte) begin
                            phase <= ph_drain;
                        end else begin
                            byte_idx <= byte_idx + 2'd1;
                        end
                    end
                end
                ph_drain: begin
                    if (tx_ready) begin
                        phase <= ph_idle;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    a_tx_data_held: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> $stable(tx_data));

endmodule

//--- rtl/tpu_uart_ctrl.sv
`timescale 1ns/1ps

module tpu_uart_ctrl
    import tpu_uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_rx,
    output logic       uart_tx,
    output logic       wf_push_col0,
    output logic       wf_push_col1,
    output byte_t      wf_data_in,
    output logic       init_act_valid,
    output act_row_t   init_act_data,
    output logic       start_mlp,
    output logic       weights_ready,
    input  mlp_state_t mlp_state,
    input  cycle_cnt_t mlp_cycle_cnt,
    input  acc_t       mlp_acc0
);

    byte_t rx_data;
    logic  rx_valid;
    byte_t tx_data;
    logic  tx_valid;
    logic  tx_ready;
    logic  load_en;
    logic  load_weight;
    logic  load_done;
    logic  capture_result;
    logic  capture_status;
    logic  resp_done;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (uart_tx)
    );

    cmd_ctrl u_cmd_ctrl (
        .clk            (clk),
        .rst            (rst),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .load_done      (load_done),
        .resp_done      (resp_done),
        .load_en        (load_en),
        .load_weight    (load_weight),
        .start_mlp      (start_mlp),
        .capture_result (capture_result),
        .capture_status (capture_status)
    );

    mlp_loader u_mlp_loader (
        .clk            (clk),
        .rst            (rst),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .load_en        (load_en),
        .load_weight    (load_weight),
        .wf_push_col0   (wf_push_col0),
        .wf_push_col1   (wf_push_col1),
        .wf_data_in     (wf_data_in),
        .init_act_valid (init_act_valid),
        .init_act_data  (init_act_data),
        .weights_ready  (weights_ready),
        .load_done      (load_done)
    );

    resp_serializer u_resp_serializer (
        .clk            (clk),
        .rst            (rst),
        .capture_result (capture_result),
        .capture_status (capture_status),
        .mlp_state      (mlp_state),
        .mlp_cycle_cnt  (mlp_cycle_cnt),
        .mlp_acc0       (mlp_acc0),
        .tx_ready       (tx_ready),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .resp_done      (resp_done)
    );

endmodule

//--- dv/tb_tpu_uart_ctrl.sv
`timescale 1ns/1ps

module tb_tpu_uart_ctrl;

    localparam int     bit_clks    = 16;
    localparam int     frame_clks  = 10 * bit_clks;
    localparam int     gap_clks    = 2 * bit_clks;
    localparam int     num_cmds    = 60;
    localparam longint watchdog_ns = longint'(num_cmds) * 9 * 160 * 100 * 2;

    logic        clk;
    logic        rst;
    logic        uart_rx;
    logic        uart_tx;
    logic        wf_push_col0;
    logic        wf_push_col1;
    logic [7:0]  wf_data_in;
    logic        init_act_valid;
    logic [15:0] init_act_data;
    logic        start_mlp;
    logic        weights_ready;
    logic [3:0]  mlp_state;
    logic [4:0]  mlp_cycle_cnt;
    logic [31:0] mlp_acc0;

    logic [31:0] seed;
    int          cycle;
    int          mismatches;
    int          failures;
    bit          weights_written;
    bit          ready_seen;

    // MLP model values, copied onto the DUT inputs
    logic [3:0]  model_state;
    logic [4:0]  model_cnt;
    logic [31:0] model_acc;

    // Events from the monitors, drained after each command
    int          push_cyc  [$];
    bit          push_col  [$];
    logic [7:0]  push_dat  [$];
    logic        push_rdy  [$];
    int          row_cyc   [$];
    logic [15:0] row_dat   [$];
    int          start_cyc [$];
    logic [7:0]  tx_bytes  [$];

    tpu_uart_ctrl u_tpu_uart_ctrl (
        .clk            (clk),
        .rst            (rst),
        .uart_rx        (uart_rx),
        .uart_tx        (uart_tx),
        .wf_push_col0   (wf_push_col0),
        .wf_push_col1   (wf_push_col1),
        .wf_data_in     (wf_data_in),
        .init_act_valid (init_act_valid),
        .init_act_data  (init_act_data),
        .start_mlp      (start_mlp),
        .weights_ready  (weights_ready),
        .mlp_state      (mlp_state),
        .mlp_cycle_cnt  (mlp_cycle_cnt),
        .mlp_acc0       (mlp_acc0)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        seed = xorshift32(seed);
        return seed;
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        mismatches++;
        $display("MISMATCH %s expected 0x%0h actual 0x%0h", test, exp, act);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("ERROR %s", what);
    endtask

    // Start bit, data LSB first, stop bit
    task automatic send_frame(input logic [7:0] b, output int start);
        start   = cycle;
        uart_rx = 1'b0;
        repeat (bit_clks) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            uart_rx = b[i];
            repeat (bit_clks) @(negedge clk);
        end
        uart_rx = 1'b1;
        repeat (bit_clks) @(negedge clk);
    endtask

    function automatic int event_count(input int kind);
        case (kind)
            0: return push_cyc.size();
            1: return row_cyc.size();
            2: return start_cyc.size();
            default: return tx_bytes.size();
        endcase
    endfunction

    task automatic wait_events(input int kind, input int count, input int limit,
                               input string test);
        int n;
        n = 0;
        while (event_count(kind) < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (event_count(kind) != count) begin
            report_failure($sformatf("%s expected %0d events but saw %0d",
                                     test, count, event_count(kind)));
        end
    endtask

    task automatic clear_events();
        push_cyc.delete();
        push_col.delete();
        push_dat.delete();
        push_rdy.delete();
        row_cyc.delete();
        row_dat.delete();
        start_cyc.delete();
        tx_bytes.delete();
    endtask

    // Nothing may be pending once a command is finished
    task automatic check_quiet(input string test);
        if (push_cyc.size() != 0 || row_cyc.size() != 0 || start_cyc.size() != 0) begin
            report_failure($sformatf("%s left stray push, row or start pulses", test));
        end
        if (tx_bytes.size() != 0) begin
            report_failure($sformatf("%s left %0d stray response bytes", test, tx_bytes.size()));
        end
        if (weights_ready !== weights_written) begin
            report_mismatch({test, " weights_ready"}, weights_written, weights_ready);
        end
        clear_events();
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (wf_push_col0 && wf_push_col1) begin
                report_failure("both weight push strobes high in one cycle");
            end
            if (wf_push_col0 || wf_push_col1) begin
                push_cyc.push_back(cycle);
                push_col.push_back(wf_push_col1);
                push_dat.push_back(wf_data_in);
                push_rdy.push_back(weights_ready);
            end
            if (init_act_valid) begin
                row_cyc.push_back(cycle);
                row_dat.push_back(init_act_data);
            end
            if (start_mlp) begin
                start_cyc.push_back(cycle);
            end
            // Sticky until reset
            if (ready_seen && !weights_ready) begin
                report_failure("weights_ready dropped after going high");
                ready_seen = 1'b0;
            end else if (weights_ready) begin
                ready_seen = 1'b1;
            end
        end
    end

    // Serial monitor, samples near bit centres
    initial begin
        logic [7:0] b;
        forever begin
            @(negedge clk);
            if (!rst && uart_tx === 1'b0) begin
                repeat (bit_clks / 2) @(negedge clk);
                if (uart_tx === 1'b0) begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (bit_clks) @(negedge clk);
                        b[i] = uart_tx;
                    end
                    repeat (bit_clks) @(negedge clk);
                    if (uart_tx === 1'b1) begin
                        tx_bytes.push_back(b);
                    end else begin
                        report_failure("uart_tx frame has a low stop bit");
                    end
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before all commands completed");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int          fc;
        int          sel;
        logic [31:0] r;
        logic [7:0]  code;
        logic [7:0]  d [4];
        string       name;

        rst             = 1'b1;
        uart_rx         = 1'b1;
        mlp_state       = '0;
        mlp_cycle_cnt   = '0;
        mlp_acc0        = '0;
        seed            = 32'h5fe2d4b2;
        cycle           = 0;
        mismatches      = 0;
        failures        = 0;
        weights_written = 1'b0;
        ready_seen      = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (gap_clks) @(negedge clk);
        check_quiet("reset");

        for (int n = 0; n < num_cmds; n++) begin
            // MLP inputs only move while the DUT is idle
            r             = next_random();
            model_state   = r[3:0];
            model_cnt     = r[8:4];
            model_acc     = next_random();
            mlp_state     = model_state;
            mlp_cycle_cnt = model_cnt;
            mlp_acc0      = model_acc;
            for (int k = 0; k < 4; k++) begin
                r    = next_random();
                d[k] = r[7:0];
            end
            sel = int'(next_random() % 7);
            case (sel)
                0: begin
                    name = "write_weight";
                    send_frame(8'h01, fc);
                    for (int k = 0; k < 4; k++) begin
                        send_frame(d[k], fc);
                    end
                    wait_events(0, 4, gap_clks, name);
                    if (push_cyc.size() == 4) begin
                        for (int k = 0; k < 4; k++) begin
                            if (push_col[k] != (k % 2)) begin
                                report_mismatch({name, " column"}, k % 2, push_col[k]);
                            end
                            if (push_dat[k] !== d[k]) begin
                                report_mismatch({name, " data"}, d[k], push_dat[k]);
                            end
                            if (push_rdy[k] !== (k == 3 || weights_written)) begin
                                report_mismatch({name, " weights_ready"},
                                                (k == 3 || weights_written), push_rdy[k]);
                            end
                            if (push_cyc[k] != push_cyc[0] + k) begin
                                report_failure("write_weight pushes not on consecutive cycles");
                            end
                        end
                    end
                    weights_written = 1'b1;
                    clear_events();
                end
                1: begin
                    name = "write_act";
                    send_frame(8'h02, fc);
                    for (int k = 0; k < 4; k++) begin
                        send_frame(d[k], fc);
                    end
                    wait_events(1, 2, gap_clks, name);
                    if (row_cyc.size() == 2) begin
                        if (row_dat[0] !== {d[1], d[0]}) begin
                            report_mismatch({name, " row0"}, {d[1], d[0]}, row_dat[0]);
                        end
                        if (row_dat[1] !== {d[3], d[2]}) begin
                            report_mismatch({name, " row1"}, {d[3], d[2]}, row_dat[1]);
                        end
                        if (row_cyc[1] != row_cyc[0] + 1) begin
                            report_failure("write_act rows not on consecutive cycles");
                        end
                    end
                    clear_events();
                end
                2: begin
                    name = "execute";
                    send_frame(8'h03, fc);
                    wait_events(2, 1, gap_clks, name);
                    // Pulse follows the sample at the middle of the stop bit
                    if (start_cyc.size() == 1 &&
                        (start_cyc[0] < fc + 9 * bit_clks + bit_clks / 2 ||
                         start_cyc[0] > fc + frame_clks + 2)) begin
                        report_failure($sformatf("execute start_mlp at cycle %0d, frame began %0d",
                                                 start_cyc[0], fc));
                    end
                    start_cyc.delete();
                    repeat (2 * frame_clks) @(negedge clk);
                end
                3: begin
                    name = "read_result";
                    send_frame(8'h04, fc);
                    wait_events(3, 4, 5 * frame_clks, name);
                    if (tx_bytes.size() == 4) begin
                        for (int k = 0; k < 4; k++) begin
                            if (tx_bytes[k] !== model_acc[8*k +: 8]) begin
                                report_mismatch($sformatf("%s byte%0d", name, k),
                                                model_acc[8*k +: 8], tx_bytes[k]);
                            end
                        end
                    end
                    clear_events();
                end
                4: begin
                    name = "status";
                    send_frame(8'h05, fc);
                    wait_events(3, 1, 2 * frame_clks, name);
                    if (tx_bytes.size() == 1 && tx_bytes[0] !== {model_state[2:0], model_cnt}) begin
                        report_mismatch(name, {model_state[2:0], model_cnt}, tx_bytes[0]);
                    end
                    clear_events();
                end
                default: begin
                    name = "invalid";
                    r    = next_random();
                    code = r[7:0];
                    if (code >= 8'h01 && code <= 8'h05) begin
                        code = code + 8'h10;
                    end
                    send_frame(code, fc);
                    // Long enough for any reply to show up
                    repeat (2 * frame_clks) @(negedge clk);
                end
            endcase
            repeat (gap_clks) @(negedge clk);
            check_quiet(name);
        end

        repeat (2 * frame_clks) @(negedge clk);
        check_quiet("end of run");
        $display("Run complete with %0d mismatches and %0d other failures",
                 mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
rtl/tpu_uart_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_ctrl.sv
rtl/mlp_loader.sv
rtl/resp_serializer.sv
rtl/tpu_uart_ctrl.sv
dv/tb_tpu_uart_ctrl.sv

//--- Bender.yml
package:
  name: tpu_uart_ctrl

sources:
  - files:
      - rtl/tpu_uart_pkg.sv
      - rtl/uart_rx.sv
      - rtl/uart_tx.sv
      - rtl/cmd_ctrl.sv
      - rtl/mlp_loader.sv
      - rtl/resp_serializer.sv
      - rtl/tpu_uart_ctrl.sv
  - target: simulation
    files:
      - dv/tb_tpu_uart_ctrl.sv
